//--- Makefile
# Verilator build and run for the Booth multiplier

VERILATOR ?= verilator
TOP       ?= booth_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_MSG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+design
design/booth_pkg.sv
design/booth_controller.sv
design/booth_datapath.sv
design/booth_multiplier.sv
bench/booth_asserts.sv
bench/booth_tb.sv

//--- bench/booth_asserts.sv
`include "booth_cfg.svh"

module booth_asserts (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done
);

    logic [7:0] busy_len;   // Edges with busy high in the current run

    // Run length tracker
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_len <= '0;
        end else if (busy) begin
            busy_len <= busy_len + 8'd1;
        end else begin
            busy_len <= '0;     // Cleared between runs
        end
    end

    // Done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Product phase never overlaps the steps
    done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(done && busy))
        else $error("done and busy high together");

    // One step per operand bit
    busy_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> (busy_len == 8'(`BOOTH_WIDTH_M)))
        else $error("busy run length differs from the operand width");

    // Quiet while held in reset
    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!busy && !done))
        else $error("busy or done high during reset");

endmodule

// Attach to every multiplier instance
bind booth_multiplier booth_asserts booth_asserts_i (
    .clk   (clk),
    .rst_n (rst_n),
    .busy  (busy),
    .done  (done)
);

//--- bench/booth_tb.sv
`include "booth_cfg.svh"

module booth_tb;

    localparam int w           = `BOOTH_WIDTH_M;
    localparam int half_period = 20;
    localparam int drive_delay = 2;        // Inputs change this long after a rising edge
    localparam int reset_cycles = 5;
    localparam int latency     = `BOOTH_WIDTH_M + 1;   // Accepting edge to done edge
    localparam int done_limit  = 2 * latency + 8;      // Give up on done after this
    localparam int n_corner    = 12;
    localparam int n_random    = 200;
    localparam int n_products  = n_corner + n_random + 4;
    localparam int cycles_per_product = 20;
    localparam int margin_cycles      = 200;
    localparam longint watchdog_time  =
        longint'(n_products * cycles_per_product + margin_cycles) * 2 * half_period;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    booth_pkg::operands_t operands;
    logic                 busy;
    logic                 done;
    booth_pkg::product_t  product;

    int          err_count;     // Failed checks over the run
    int          tests_passed;
    int          tests_failed;

    booth_multiplier booth_multiplier_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .operands (operands),
        .busy     (busy),
        .done     (done),
        .product  (product)
    );

    initial clk = 1'b0;
    always #(half_period) clk = ~clk;

    // Hard stop if something never finishes
    initial begin
        #(watchdog_time);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    // Move to the drive slot of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic check_product(string name, booth_pkg::product_t expected,
                                 booth_pkg::product_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    function automatic booth_pkg::operands_t make_ops(logic [w-1:0] mcand,
                                                      logic [w-1:0] mplier);
        booth_pkg::operands_t ops;
        ops.multiplicand = mcand;
        ops.multiplier   = mplier;
        return ops;
    endfunction

    // Reference product from sign extended operands
    function automatic booth_pkg::product_t signed_product(booth_pkg::operands_t ops);
        booth_pkg::product_t a;
        booth_pkg::product_t b;
        a = {{w{ops.multiplicand[w-1]}}, ops.multiplicand};
        b = {{w{ops.multiplier[w-1]}}, ops.multiplier};
        return a * b;
    endfunction

    // Called in a drive slot and returns in the slot after the accepting edge
    task automatic issue_start(booth_pkg::operands_t ops);
        start    = 1'b1;
        operands = ops;
        next_cycle();
        start    = 1'b0;
        operands = ~ops;    // Garbage that must not be sampled
    endtask

    // Edges counted from the accepting edge with done read in the slot before its edge
    task automatic wait_done(output int edges, output logic seen);
        edges = 1;
        seen  = 1'b0;
        while (edges <= done_limit) begin
            if (done === 1'b1) begin
                seen = 1'b1;
                break;
            end
            next_cycle();
            edges++;
        end
    endtask

    // One full product with latency check that ends one cycle past done
    task automatic multiply_check(booth_pkg::operands_t ops);
        int   edges;
        logic seen;
        issue_start(ops);
        wait_done(edges, seen);
        if (!seen) begin
            $display("No done pulse for operands %h and %h",
                     ops.multiplicand, ops.multiplier);
            err_count++;
        end else begin
            check_product("product", signed_product(ops), product);
            if (edges != latency) begin
                $display("Done came %0d edges after start instead of %0d", edges, latency);
                err_count++;
            end
        end
        next_cycle();   // Past the done cycle and idle from here
    endtask

    task automatic finish_test(string name, int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("[PASS] %s", name);
            tests_passed++;
        end else begin
            $display("[FAIL] %s with %0d errors", name, err_count - errs_at_start);
            tests_failed++;
        end
    endtask

    task automatic reset_state();
        int errs;
        errs = err_count;
        repeat (8) begin
            check_flag("busy", 1'b0, busy);
            check_flag("done", 1'b0, done);
            check_product("product", '0, product);   // Registers cleared by reset
            next_cycle();
        end
        finish_test("reset_state", errs);
    endtask

    task automatic corner_products();
        int           errs;
        logic [w-1:0] zero;
        logic [w-1:0] one;
        logic [w-1:0] neg_one;
        logic [w-1:0] max_pos;
        logic [w-1:0] max_neg;
        errs    = err_count;
        zero    = '0;
        one     = w'(1);
        neg_one = '1;
        max_pos = {1'b0, {(w-1){1'b1}}};
        max_neg = {1'b1, {(w-1){1'b0}}};
        multiply_check(make_ops(zero, zero));
        multiply_check(make_ops(zero, max_neg));
        multiply_check(make_ops(one, one));
        multiply_check(make_ops(neg_one, neg_one));
        multiply_check(make_ops(one, neg_one));
        multiply_check(make_ops(max_pos, one));
        multiply_check(make_ops(max_pos, max_pos));
        multiply_check(make_ops(max_neg, max_neg));   // Largest magnitude product
        multiply_check(make_ops(max_neg, max_pos));
        multiply_check(make_ops(max_pos, max_neg));
        multiply_check(make_ops(neg_one, max_neg));
        multiply_check(make_ops(max_neg, neg_one));
        finish_test("corner_products", errs);
    endtask

    task automatic random_products();
        int errs;
        errs = err_count;
        for (int i = 0; i < n_random; i++) begin
            multiply_check(make_ops(w'($urandom), w'($urandom)));
        end
        finish_test("random_products", errs);
    endtask

    // Walks every edge from E1 to E18
    task automatic fixed_latency();
        int                   errs;
        booth_pkg::operands_t ops;
        errs = err_count;
        ops  = make_ops(w'(-7), w'(13));
        issue_start(ops);
        for (int k = 1; k <= latency + 1; k++) begin
            check_flag("done", (k == latency), done);
            check_flag("busy", (k < latency), busy);
            if (k == latency) begin
                check_product("product", signed_product(ops), product);
            end
            next_cycle();
        end
        finish_test("fixed_latency", errs);
    endtask

    task automatic start_ignored();
        int                   errs;
        int                   edges;
        logic                 seen;
        booth_pkg::operands_t ops_a;
        booth_pkg::operands_t ops_b;
        errs  = err_count;
        ops_a = make_ops(w'(1234), w'(-321));
        ops_b = make_ops(w'(-5), w'(77));
        issue_start(ops_a);
        repeat (4) next_cycle();
        start    = 1'b1;        // Mid-run request
        operands = ops_b;
        next_cycle();
        start    = 1'b0;
        wait_done(edges, seen);
        if (!seen) begin
            $display("No done pulse after a start issued mid-run");
            err_count++;
        end else begin
            check_product("product", signed_product(ops_a), product);
        end
        start    = 1'b1;        // Sampled in the done cycle
        operands = ops_b;
        next_cycle();
        start    = 1'b0;
        repeat (latency + 8) begin
            check_flag("done", 1'b0, done);     // No second pulse
            check_flag("busy", 1'b0, busy);
            next_cycle();
        end
        check_product("product", signed_product(ops_a), product);  // Still held
        finish_test("start_ignored", errs);
    endtask

    // Second start lands on the first idle edge
    task automatic back_to_back();
        int errs;
        errs = err_count;
        multiply_check(make_ops(w'(-300), w'(-411)));
        multiply_check(make_ops(w'(2047), w'(-9)));
        finish_test("back_to_back", errs);
    endtask

    initial begin
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'hea4a));
        rst_n        = 1'b0;
        start        = 1'b0;
        operands     = '0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;

        reset_state();
        corner_products();
        random_products();
        fixed_latency();
        start_ignored();
        back_to_back();

        $display("Summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- design/booth_cfg.svh
`ifndef BOOTH_CFG_SVH
`define BOOTH_CFG_SVH

// Operand width, any even value from 4 to 32
`define BOOTH_WIDTH_M 16

// Full signed product
`define BOOTH_WIDTH_P (2 * `BOOTH_WIDTH_M)

// Step counter must reach BOOTH_WIDTH_M itself
`define BOOTH_CNT_W ($clog2(`BOOTH_WIDTH_M + 1))

`endif

//--- design/booth_controller.sv
`include "booth_cfg.svh"

module booth_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,   // One-cycle request
    input  booth_pkg::booth_bits_t bits,    // Current Booth pair from datapath
    output booth_pkg::ctrl_t       ctrl,
    output logic                   busy,    // High through all steps
    output logic                   done     // One-cycle pulse, product valid
);

    localparam int cnt_w = `BOOTH_CNT_W;
    localparam logic [cnt_w-1:0] last_step = cnt_w'(`BOOTH_WIDTH_M);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } state_t;

    state_t             state;
    state_t             state_next;
    logic [cnt_w-1:0]   cnt;        // Steps already taken
    logic [cnt_w-1:0]   cnt_inc;
    logic               accept;     // Start seen while idle
    logic               run;
    booth_pkg::alu_op_t op;

    // Start only counts in idle, ignored while busy or done
    assign accept  = start && (state == st_idle);
    assign run     = (state == st_run);
    assign cnt_inc = cnt + 1'b1;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_next = st_run;
                end
            end
            st_run: begin
                // Last step lands on this edge
                if (cnt_inc == last_step) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                state_next = st_idle;   // Done is a single cycle
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Step counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (accept) begin
            cnt <= '0;          // Fresh product
        end else if (run) begin
            cnt <= cnt_inc;
        end
    end

    // Booth rule on the pair {q0, q_1}
    always_comb begin
        case ({bits.q0, bits.q_1})
            2'b10:   op = booth_pkg::ALU_SUB;
            2'b01:   op = booth_pkg::ALU_ADD;
            default: op = booth_pkg::ALU_PASS;  // 00 and 11
        endcase
    end

    assign ctrl.load   = accept;
    assign ctrl.step   = run;
    assign ctrl.alu_op = run ? op : booth_pkg::ALU_PASS; // Quiet outside run

    assign busy = run;
    assign done = (state == st_done);

endmodule

//--- design/booth_datapath.sv
`include "booth_cfg.svh"

module booth_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  booth_pkg::operands_t   operands,   // Sampled only on load
    input  booth_pkg::ctrl_t       ctrl,
    output booth_pkg::booth_bits_t bits,       // Pair for the next step
    output booth_pkg::product_t    product     // {A, Q} straight from registers
);

    localparam int w = `BOOTH_WIDTH_M;

    // Registers
    logic signed [w-1:0] mcand;    // Multiplicand M, held for the whole run
    logic signed [w-1:0] acc;      // Accumulator A
    logic        [w-1:0] mq;       // Multiplier Q, fills with low product bits
    logic                q_1;      // Bit shifted out of Q last step

    // Step logic
    logic signed [w:0]   acc_ext;  // A with one guard bit
    logic signed [w:0]   mcand_ext;
    logic signed [w:0]   sum_ext;  // A op M before the shift
    logic signed [w-1:0] acc_next;
    logic        [w-1:0] mq_next;
    logic                q_1_next;

    // Guard bit keeps A - M exact for the most negative M
    assign acc_ext   = {acc[w-1], acc};
    assign mcand_ext = {mcand[w-1], mcand};

    // Add/subtract unit
    always_comb begin
        case (ctrl.alu_op)
            booth_pkg::ALU_ADD: begin
                sum_ext = acc_ext + mcand_ext;
            end
            booth_pkg::ALU_SUB: begin
                sum_ext = acc_ext - mcand_ext;
            end
            default: begin
                sum_ext = acc_ext;          // Pass, A unchanged
            end
        endcase
    end

    // Arithmetic right shift of {A, Q, Q_1} as one unit
    assign acc_next = sum_ext[w:1];              // Guard bit becomes the new sign
    assign mq_next  = {sum_ext[0], mq[w-1:1]};   // LSB of A moves into Q
    assign q_1_next = mq[0];                     // Q0 drops into Q_1

    // Multiplicand only changes on load
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            mcand <= operands.multiplicand;
        end
    end

    // A, Q and Q_1 cleared by reset so the product reads zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            mq  <= '0;
            q_1 <= 1'b0;
        end else if (ctrl.load) begin
            acc <= '0;
            mq  <= operands.multiplier;
            q_1 <= 1'b0;
        end else if (ctrl.step) begin
            acc <= acc_next;
            mq  <= mq_next;
            q_1 <= q_1_next;
        end
    end

    // Booth pair back to the controller
    assign bits.q0  = mq[0];
    assign bits.q_1 = q_1;

    // Exact signed product once all steps are done
    assign product = {acc, mq};

endmodule

//--- design/booth_multiplier.sv
module booth_multiplier (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,      // One-cycle strobe
    input  booth_pkg::operands_t operands,   // Taken with an accepted start
    output logic                 busy,       // Steps in progress
    output logic                 done,       // One cycle, product valid
    output booth_pkg::product_t  product
);

    booth_pkg::ctrl_t       ctrl;   // Load, step and ALU op
    booth_pkg::booth_bits_t bits;   // Q0 and Q_1 back up

    // Sequencing and Booth decisions
    booth_controller booth_controller_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .bits  (bits),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    // Registers, adder and shifter
    booth_datapath booth_datapath_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .operands (operands),
        .ctrl     (ctrl),
        .bits     (bits),
        .product  (product)
    );

endmodule

//--- design/booth_pkg.sv
`include "booth_cfg.svh"

package booth_pkg;

    // Accumulator action for one Booth step
    typedef enum logic [1:0] {
        ALU_PASS = 2'b00,   // Pair 00 or 11
        ALU_ADD  = 2'b01,   // Pair 01, end of a run of ones
        ALU_SUB  = 2'b10    // Pair 10, start of a run of ones
    } alu_op_t;

    // Operand pair, captured on an accepted start
    typedef struct packed {
        logic signed [`BOOTH_WIDTH_M-1:0] multiplicand;
        logic signed [`BOOTH_WIDTH_M-1:0] multiplier;
    } operands_t;

    // Controller to datapath
    typedef struct packed {
        logic    load;      // Capture operands, zero A and Q_1
        logic    step;      // One add/sub plus shift
        alu_op_t alu_op;    // Only meaningful with step
    } ctrl_t;

    // Datapath to controller, the pair that drives the Booth rule
    typedef struct packed {
        logic q0;   // LSB of multiplier register
        logic q_1;  // Extra bit shifted out last step
    } booth_bits_t;

    // Full product, A concatenated with Q
    typedef logic signed [`BOOTH_WIDTH_P-1:0] product_t;

endpackage
